/* logic/lsq_pkg.sv */
`default_nettype none

package lsq_pkg;

  // Memory ops accepted per cycle
  localparam int NUM_SUPER = 2;

  // Slots per queue, one always left empty
  // Must stay a power of two for the pointer wrap
  localparam int NUM_LSQ = 8;

  localparam int IDX_W = $clog2(NUM_LSQ);

  // Doubleword address; byte offset bits are not stored
  localparam int ADDR_W = 29;

  localparam int DATA_W = 64;

endpackage

`default_nettype wire

/* logic/store_forward_search.sv */
`timescale 1ns/1ps
`default_nettype none

module store_forward_search (
  input  logic [lsq_pkg::NUM_LSQ-1:0]                      entry_valid,
  input  logic [lsq_pkg::NUM_LSQ-1:0][lsq_pkg::ADDR_W-1:0] entry_addr,
  input  logic [lsq_pkg::IDX_W-1:0]                        head,
  input  logic [lsq_pkg::IDX_W-1:0]                        bound,
  input  logic [lsq_pkg::ADDR_W-1:0]                       query_addr,
  output logic                                             hit,
  output logic [lsq_pkg::IDX_W-1:0]                        hit_idx
);

  // Stores older than the load occupy [head, bound)
  logic [lsq_pkg::IDX_W-1:0] span;

  assign span = bound - head;

  always_comb begin
    logic [lsq_pkg::IDX_W-1:0] slot;
    logic [lsq_pkg::IDX_W-1:0] left;
    hit     = 1'b0;
    hit_idx = '0;
    slot    = bound;
    left    = span;
    // Walk backward so the youngest match wins
    for (int k = 0; k < lsq_pkg::NUM_LSQ; k++) begin
      slot = slot - 1'b1;
      if (left != '0 && !hit && entry_valid[slot] && entry_addr[slot] == query_addr) begin
        hit     = 1'b1;
        hit_idx = slot;
      end
      if (left != '0) begin
        left = left - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue (
  input  logic                                               clock,
  input  logic                                               reset,
  input  logic [lsq_pkg::NUM_SUPER-1:0]                      st_dispatch,
  output logic                                               st_dispatch_ready,
  output logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  st_alloc_idx,
  input  logic [lsq_pkg::NUM_SUPER-1:0]                      st_exec_valid,
  input  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  st_exec_idx,
  input  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::ADDR_W-1:0] st_exec_addr,
  input  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::DATA_W-1:0] st_exec_data,
  input  logic [lsq_pkg::NUM_SUPER-1:0]                      fwd_query_valid,
  input  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::ADDR_W-1:0] fwd_query_addr,
  input  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  fwd_query_bound,
  output logic [lsq_pkg::NUM_SUPER-1:0]                      fwd_hit,
  output logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::DATA_W-1:0] fwd_data,
  input  logic [lsq_pkg::NUM_SUPER-1:0]                      st_retire,
  output logic [lsq_pkg::NUM_SUPER-1:0]                      st_retire_ready,
  output logic [lsq_pkg::NUM_SUPER-1:0]                      cache_wr_en,
  output logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::ADDR_W-1:0] cache_wr_addr,
  output logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::DATA_W-1:0] cache_wr_data,
  input  logic                                               rollback_en,
  input  logic [lsq_pkg::IDX_W-1:0]                          sq_rollback_tail,
  output logic [lsq_pkg::IDX_W-1:0]                          sq_head,
  output logic [lsq_pkg::IDX_W-1:0]                          sq_boundary
);

  logic [lsq_pkg::IDX_W-1:0]                       head;
  logic [lsq_pkg::IDX_W-1:0]                       tail;
  logic [lsq_pkg::IDX_W-1:0]                       next_head;
  logic [lsq_pkg::IDX_W-1:0]                       next_tail;
  logic [lsq_pkg::IDX_W-1:0]                       alloc_end;
  logic [lsq_pkg::IDX_W:0]                         need;
  logic                                            alloc_fire;
  logic [lsq_pkg::NUM_LSQ-1:0]                     executed;
  logic [lsq_pkg::NUM_LSQ-1:0][lsq_pkg::ADDR_W-1:0] st_addr;
  logic [lsq_pkg::NUM_LSQ-1:0][lsq_pkg::DATA_W-1:0] st_data;
  logic [lsq_pkg::NUM_SUPER-1:0]                   search_hit;
  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0] hit_idx;

  // Requested lanes take consecutive slots from the tail
  always_comb begin
    alloc_end = tail;
    for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
      st_alloc_idx[i] = alloc_end;
      if (st_dispatch[i]) begin
        alloc_end = alloc_end + 1'b1;
      end
    end
  end

  // Occupancy plus request must stay below NUM_LSQ
  assign need              = {1'b0, tail - head} + {1'b0, alloc_end - tail};
  assign st_dispatch_ready = ~need[lsq_pkg::IDX_W];
  assign alloc_fire        = st_dispatch_ready & ~rollback_en;
  assign sq_boundary       = alloc_fire ? alloc_end : tail;
  assign next_tail         = rollback_en ? sq_rollback_tail : sq_boundary;
  assign sq_head           = head;

  // In-order retire to the cache write port
  always_comb begin
    logic [lsq_pkg::IDX_W-1:0] slot;
    logic [lsq_pkg::IDX_W-1:0] left;
    slot      = head;
    left      = tail - head;
    next_head = head;
    for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
      st_retire_ready[i] = (left != '0) && executed[slot];
      cache_wr_en[i]     = st_retire[i] & st_retire_ready[i];
      cache_wr_addr[i]   = st_addr[slot];
      cache_wr_data[i]   = st_data[slot];
      if (cache_wr_en[i]) begin
        next_head = next_head + 1'b1;
      end
      if (st_retire[i]) begin
        slot = slot + 1'b1;
        if (left != '0) begin
          left = left - 1'b1;
        end
      end
    end
  end

  for (genvar i = 0; i < lsq_pkg::NUM_SUPER; i++) begin : g_fwd
    store_forward_search u_search (
      .entry_valid (executed),
      .entry_addr  (st_addr),
      .head        (head),
      .bound       (fwd_query_bound[i]),
      .query_addr  (fwd_query_addr[i]),
      .hit         (search_hit[i]),
      .hit_idx     (hit_idx[i])
    );

    assign fwd_hit[i]  = fwd_query_valid[i] & search_hit[i];
    assign fwd_data[i] = st_data[hit_idx[i]];
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head     <= '0;
      tail     <= '0;
      executed <= '0;
    end else begin
      head <= next_head;
      tail <= next_tail;
      for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
        if (alloc_fire && st_dispatch[i]) begin
          executed[st_alloc_idx[i]] <= 1'b0;
        end
      end
      for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
        if (st_exec_valid[i]) begin
          executed[st_exec_idx[i]] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
      if (st_exec_valid[i]) begin
        st_addr[st_exec_idx[i]] <= st_exec_addr[i];
        st_data[st_exec_idx[i]] <= st_exec_data[i];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/load_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module load_queue (
  input  logic                                               clock,
  input  logic                                               reset,
  input  logic [lsq_pkg::NUM_SUPER-1:0]                      ld_dispatch,
  output logic                                               ld_dispatch_ready,
  output logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  ld_alloc_idx,
  input  logic [lsq_pkg::NUM_SUPER-1:0]                      ld_exec_valid,
  input  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  ld_exec_idx,
  input  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::ADDR_W-1:0] ld_exec_addr,
  input  logic [lsq_pkg::NUM_SUPER-1:0]                      st_exec_valid,
  input  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  st_exec_idx,
  input  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::ADDR_W-1:0] st_exec_addr,
  input  logic [lsq_pkg::IDX_W-1:0]                          sq_head,
  input  logic [lsq_pkg::IDX_W-1:0]                          sq_boundary,
  output logic [lsq_pkg::NUM_SUPER-1:0]                      fwd_query_valid,
  output logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::ADDR_W-1:0] fwd_query_addr,
  output logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  fwd_query_bound,
  output logic [lsq_pkg::NUM_SUPER-1:0]                      violation,
  output logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  violation_lq_idx,
  input  logic [lsq_pkg::NUM_SUPER-1:0]                      ld_retire,
  input  logic                                               rollback_en,
  input  logic [lsq_pkg::IDX_W-1:0]                          lq_rollback_tail
);

  logic [lsq_pkg::IDX_W-1:0]                        head;
  logic [lsq_pkg::IDX_W-1:0]                        tail;
  logic [lsq_pkg::IDX_W-1:0]                        next_head;
  logic [lsq_pkg::IDX_W-1:0]                        next_tail;
  logic [lsq_pkg::IDX_W-1:0]                        alloc_end;
  logic [lsq_pkg::IDX_W:0]                          need;
  logic                                             alloc_fire;
  logic [lsq_pkg::NUM_LSQ-1:0]                      executed;
  logic [lsq_pkg::NUM_LSQ-1:0][lsq_pkg::ADDR_W-1:0] ld_addr;
  logic [lsq_pkg::NUM_LSQ-1:0][lsq_pkg::IDX_W-1:0]  ld_bound;
  logic [lsq_pkg::NUM_LSQ-1:0]                      eff_exec;
  logic [lsq_pkg::NUM_LSQ-1:0][lsq_pkg::ADDR_W-1:0] eff_addr;
  logic [lsq_pkg::NUM_LSQ-1:0][lsq_pkg::IDX_W-1:0]  bound_dist;

  always_comb begin
    alloc_end = tail;
    for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
      ld_alloc_idx[i] = alloc_end;
      if (ld_dispatch[i]) begin
        alloc_end = alloc_end + 1'b1;
      end
    end
  end

  assign need              = {1'b0, tail - head} + {1'b0, alloc_end - tail};
  assign ld_dispatch_ready = ~need[lsq_pkg::IDX_W];
  assign alloc_fire        = ld_dispatch_ready & ~rollback_en;
  assign next_tail         = rollback_en ? lq_rollback_tail : alloc_fire ? alloc_end : tail;

  // Executing loads query the store queue up to their captured boundary
  always_comb begin
    for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
      fwd_query_valid[i] = ld_exec_valid[i];
      fwd_query_addr[i]  = ld_exec_addr[i];
      fwd_query_bound[i] = ld_bound[ld_exec_idx[i]];
    end
  end

  // Registered state merged with loads executing this cycle
  always_comb begin
    eff_exec = executed;
    eff_addr = ld_addr;
    for (int k = 0; k < lsq_pkg::NUM_SUPER; k++) begin
      if (ld_exec_valid[k]) begin
        eff_exec[ld_exec_idx[k]] = 1'b1;
        eff_addr[ld_exec_idx[k]] = ld_exec_addr[k];
      end
    end
    for (int s = 0; s < lsq_pkg::NUM_LSQ; s++) begin
      bound_dist[s] = ld_bound[s] - sq_head;
    end
  end

  // Oldest younger load with the same address, scanned from head
  always_comb begin
    logic [lsq_pkg::IDX_W-1:0] slot;
    logic [lsq_pkg::IDX_W-1:0] left;
    logic [lsq_pkg::IDX_W-1:0] st_dist;
    for (int j = 0; j < lsq_pkg::NUM_SUPER; j++) begin
      violation[j]        = 1'b0;
      violation_lq_idx[j] = '0;
      slot                = head;
      left                = tail - head;
      st_dist             = st_exec_idx[j] - sq_head;
      for (int k = 0; k < lsq_pkg::NUM_LSQ; k++) begin
        if (st_exec_valid[j] && left != '0 && !violation[j] && eff_exec[slot] &&
            eff_addr[slot] == st_exec_addr[j] && st_dist < bound_dist[slot]) begin
          violation[j]        = 1'b1;
          violation_lq_idx[j] = slot;
        end
        slot = slot + 1'b1;
        if (left != '0) begin
          left = left - 1'b1;
        end
      end
    end
  end

  always_comb begin
    next_head = head;
    for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
      if (ld_retire[i]) begin
        next_head = next_head + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head     <= '0;
      tail     <= '0;
      executed <= '0;
    end else begin
      head     <= next_head;
      tail     <= next_tail;
      executed <= eff_exec;
      for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
        if (alloc_fire && ld_dispatch[i]) begin
          executed[ld_alloc_idx[i]] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    ld_addr <= eff_addr;
    for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
      if (alloc_fire && ld_dispatch[i]) begin
        ld_bound[ld_alloc_idx[i]] <= sq_boundary;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/lsq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_top (
  input  logic                                               clock,
  input  logic                                               reset,
  input  logic [lsq_pkg::NUM_SUPER-1:0]                      st_dispatch,
  output logic                                               st_dispatch_ready,
  output logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  st_alloc_idx,
  input  logic [lsq_pkg::NUM_SUPER-1:0]                      ld_dispatch,
  output logic                                               ld_dispatch_ready,
  output logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  ld_alloc_idx,
  input  logic [lsq_pkg::NUM_SUPER-1:0]                      st_exec_valid,
  input  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  st_exec_idx,
  input  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::ADDR_W-1:0] st_exec_addr,
  input  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::DATA_W-1:0] st_exec_data,
  input  logic [lsq_pkg::NUM_SUPER-1:0]                      ld_exec_valid,
  input  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  ld_exec_idx,
  input  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::ADDR_W-1:0] ld_exec_addr,
  output logic [lsq_pkg::NUM_SUPER-1:0]                      fwd_hit,
  output logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::DATA_W-1:0] fwd_data,
  output logic [lsq_pkg::NUM_SUPER-1:0]                      violation,
  output logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  violation_lq_idx,
  input  logic [lsq_pkg::NUM_SUPER-1:0]                      st_retire,
  output logic [lsq_pkg::NUM_SUPER-1:0]                      st_retire_ready,
  output logic [lsq_pkg::NUM_SUPER-1:0]                      cache_wr_en,
  output logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::ADDR_W-1:0] cache_wr_addr,
  output logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::DATA_W-1:0] cache_wr_data,
  input  logic [lsq_pkg::NUM_SUPER-1:0]                      ld_retire,
  input  logic                                               rollback_en,
  input  logic [lsq_pkg::IDX_W-1:0]                          sq_rollback_tail,
  input  logic [lsq_pkg::IDX_W-1:0]                          lq_rollback_tail
);

  logic [lsq_pkg::IDX_W-1:0]                        sq_head;
  logic [lsq_pkg::IDX_W-1:0]                        sq_boundary;
  logic [lsq_pkg::NUM_SUPER-1:0]                    fwd_query_valid;
  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::ADDR_W-1:0] fwd_query_addr;
  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  fwd_query_bound;

  store_queue u_sq (
    .clock             (clock),
    .reset             (reset),
    .st_dispatch       (st_dispatch),
    .st_dispatch_ready (st_dispatch_ready),
    .st_alloc_idx      (st_alloc_idx),
    .st_exec_valid     (st_exec_valid),
    .st_exec_idx       (st_exec_idx),
    .st_exec_addr      (st_exec_addr),
    .st_exec_data      (st_exec_data),
    .fwd_query_valid   (fwd_query_valid),
    .fwd_query_addr    (fwd_query_addr),
    .fwd_query_bound   (fwd_query_bound),
    .fwd_hit           (fwd_hit),
    .fwd_data          (fwd_data),
    .st_retire         (st_retire),
    .st_retire_ready   (st_retire_ready),
    .cache_wr_en       (cache_wr_en),
    .cache_wr_addr     (cache_wr_addr),
    .cache_wr_data     (cache_wr_data),
    .rollback_en       (rollback_en),
    .sq_rollback_tail  (sq_rollback_tail),
    .sq_head           (sq_head),
    .sq_boundary       (sq_boundary)
  );

  // Store execute is also broadcast here for the ordering check
  load_queue u_lq (
    .clock             (clock),
    .reset             (reset),
    .ld_dispatch       (ld_dispatch),
    .ld_dispatch_ready (ld_dispatch_ready),
    .ld_alloc_idx      (ld_alloc_idx),
    .ld_exec_valid     (ld_exec_valid),
    .ld_exec_idx       (ld_exec_idx),
    .ld_exec_addr      (ld_exec_addr),
    .st_exec_valid     (st_exec_valid),
    .st_exec_idx       (st_exec_idx),
    .st_exec_addr      (st_exec_addr),
    .sq_head           (sq_head),
    .sq_boundary       (sq_boundary),
    .fwd_query_valid   (fwd_query_valid),
    .fwd_query_addr    (fwd_query_addr),
    .fwd_query_bound   (fwd_query_bound),
    .violation         (violation),
    .violation_lq_idx  (violation_lq_idx),
    .ld_retire         (ld_retire),
    .rollback_en       (rollback_en),
    .lq_rollback_tail  (lq_rollback_tail)
  );

endmodule

`default_nettype wire

/* tests/lsq_model.svh */
`ifndef LSQ_MODEL_SVH
`define LSQ_MODEL_SVH

// Mirror of both queues, advanced once per cycle
logic [lsq_pkg::IDX_W-1:0]  m_sq_head;
logic [lsq_pkg::IDX_W-1:0]  m_sq_tail;
logic [lsq_pkg::IDX_W-1:0]  m_lq_head;
logic [lsq_pkg::IDX_W-1:0]  m_lq_tail;
logic                       m_sq_exec  [lsq_pkg::NUM_LSQ];
logic [lsq_pkg::ADDR_W-1:0] m_sq_addr  [lsq_pkg::NUM_LSQ];
logic [lsq_pkg::DATA_W-1:0] m_sq_data  [lsq_pkg::NUM_LSQ];
logic                       m_lq_exec  [lsq_pkg::NUM_LSQ];
logic [lsq_pkg::ADDR_W-1:0] m_lq_addr  [lsq_pkg::NUM_LSQ];
logic [lsq_pkg::IDX_W-1:0]  m_lq_bound [lsq_pkg::NUM_LSQ];

function automatic logic [lsq_pkg::IDX_W-1:0] wrap(input int v);
  return v[lsq_pkg::IDX_W-1:0];
endfunction

function automatic int occupancy(input logic [lsq_pkg::IDX_W-1:0] h,
                                 input logic [lsq_pkg::IDX_W-1:0] t);
  logic [lsq_pkg::IDX_W-1:0] d;
  d = t - h;
  return int'(d);
endfunction

task automatic reset_model();
  m_sq_head = '0;
  m_sq_tail = '0;
  m_lq_head = '0;
  m_lq_tail = '0;
  for (int s = 0; s < lsq_pkg::NUM_LSQ; s++) begin
    m_sq_exec[s] = 1'b0;
    m_lq_exec[s] = 1'b0;
  end
endtask

// Youngest executed store in [head, bound) with the same address
task automatic model_forward(input logic [lsq_pkg::ADDR_W-1:0] addr,
                             input logic [lsq_pkg::IDX_W-1:0] bound,
                             output logic hit, output logic [lsq_pkg::DATA_W-1:0] data);
  logic [lsq_pkg::IDX_W-1:0] slot;
  hit  = 1'b0;
  data = '0;
  slot = bound;
  while (slot != m_sq_head && !hit) begin
    slot = slot - 1'b1;
    if (m_sq_exec[slot] && m_sq_addr[slot] == addr) begin
      hit  = 1'b1;
      data = m_sq_data[slot];
    end
  end
endtask

// Oldest load younger than the store, including loads executing now
task automatic model_violation(input logic [lsq_pkg::IDX_W-1:0] st_idx,
                               input logic [lsq_pkg::ADDR_W-1:0] addr,
                               output logic v, output logic [lsq_pkg::IDX_W-1:0] idx);
  logic [lsq_pkg::IDX_W-1:0]  slot;
  logic [lsq_pkg::IDX_W-1:0]  st_age;
  logic [lsq_pkg::IDX_W-1:0]  ld_age;
  logic                       ex;
  logic [lsq_pkg::ADDR_W-1:0] a;
  v      = 1'b0;
  idx    = '0;
  slot   = m_lq_head;
  st_age = st_idx - m_sq_head;
  while (slot != m_lq_tail && !v) begin
    ex     = m_lq_exec[slot];
    a      = m_lq_addr[slot];
    ld_age = m_lq_bound[slot] - m_sq_head;
    for (int k = 0; k < lsq_pkg::NUM_SUPER; k++) begin
      if (ld_exec_valid[k] && ld_exec_idx[k] == slot) begin
        ex = 1'b1;
        a  = ld_exec_addr[k];
      end
    end
    if (ex && a == addr && st_age < ld_age) begin
      v   = 1'b1;
      idx = slot;
    end
    slot = slot + 1'b1;
  end
endtask

task automatic report_fail(input string msg);
  $display("FAIL %0t: %s", $time, msg);
  $display("SOME TESTS FAILED");
  $fatal(1, "mismatch against the reference model");
endtask

task automatic check_alloc(input string q, input logic rdy_got, input logic rdy_exp,
    input logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0] idx_got,
    input logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0] idx_exp);
  if (rdy_got !== rdy_exp) begin
    report_fail($sformatf("%s ready %b expected %b", q, rdy_got, rdy_exp));
  end
  if (idx_got !== idx_exp) begin
    report_fail($sformatf("%s alloc idx %h expected %h", q, idx_got, idx_exp));
  end
endtask

task automatic check_forward(input int lane, input logic hit_got, input logic hit_exp,
    input logic [lsq_pkg::DATA_W-1:0] data_got, input logic [lsq_pkg::DATA_W-1:0] data_exp);
  if (hit_got !== hit_exp) begin
    report_fail($sformatf("lane %0d fwd_hit %b expected %b", lane, hit_got, hit_exp));
  end
  if (hit_exp && data_got !== data_exp) begin
    report_fail($sformatf("lane %0d fwd_data %h expected %h", lane, data_got, data_exp));
  end
endtask

task automatic check_cache_write(input int lane, input logic rdy_got, input logic rdy_exp,
    input logic en_got, input logic en_exp,
    input logic [lsq_pkg::ADDR_W-1:0] addr_got, input logic [lsq_pkg::ADDR_W-1:0] addr_exp,
    input logic [lsq_pkg::DATA_W-1:0] data_got, input logic [lsq_pkg::DATA_W-1:0] data_exp);
  if (rdy_got !== rdy_exp || en_got !== en_exp) begin
    report_fail($sformatf("lane %0d retire ready/en %b%b expected %b%b",
                          lane, rdy_got, en_got, rdy_exp, en_exp));
  end
  if (en_exp && (addr_got !== addr_exp || data_got !== data_exp)) begin
    report_fail($sformatf("lane %0d cache write %h:%h expected %h:%h",
                          lane, addr_got, data_got, addr_exp, data_exp));
  end
endtask

task automatic check_violation(input int lane, input logic v_got, input logic v_exp,
    input logic [lsq_pkg::IDX_W-1:0] idx_got, input logic [lsq_pkg::IDX_W-1:0] idx_exp);
  if (v_got !== v_exp) begin
    report_fail($sformatf("lane %0d violation %b expected %b", lane, v_got, v_exp));
  end
  if (v_exp && idx_got !== idx_exp) begin
    report_fail($sformatf("lane %0d violation idx %0d expected %0d", lane, idx_got, idx_exp));
  end
endtask

`endif

/* tests/lsq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_tb;

  localparam int RUN_CYCLES = 3000;
  localparam int TIMEOUT    = 3500;

  logic                                               clock;
  logic                                               reset;
  logic [lsq_pkg::NUM_SUPER-1:0]                      st_dispatch;
  logic                                               st_dispatch_ready;
  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  st_alloc_idx;
  logic [lsq_pkg::NUM_SUPER-1:0]                      ld_dispatch;
  logic                                               ld_dispatch_ready;
  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  ld_alloc_idx;
  logic [lsq_pkg::NUM_SUPER-1:0]                      st_exec_valid;
  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  st_exec_idx;
  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::ADDR_W-1:0] st_exec_addr;
  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::DATA_W-1:0] st_exec_data;
  logic [lsq_pkg::NUM_SUPER-1:0]                      ld_exec_valid;
  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  ld_exec_idx;
  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::ADDR_W-1:0] ld_exec_addr;
  logic [lsq_pkg::NUM_SUPER-1:0]                      fwd_hit;
  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::DATA_W-1:0] fwd_data;
  logic [lsq_pkg::NUM_SUPER-1:0]                      violation;
  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0]  violation_lq_idx;
  logic [lsq_pkg::NUM_SUPER-1:0]                      st_retire;
  logic [lsq_pkg::NUM_SUPER-1:0]                      st_retire_ready;
  logic [lsq_pkg::NUM_SUPER-1:0]                      cache_wr_en;
  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::ADDR_W-1:0] cache_wr_addr;
  logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::DATA_W-1:0] cache_wr_data;
  logic [lsq_pkg::NUM_SUPER-1:0]                      ld_retire;
  logic                                               rollback_en;
  logic [lsq_pkg::IDX_W-1:0]                          sq_rollback_tail;
  logic [lsq_pkg::IDX_W-1:0]                          lq_rollback_tail;

  logic st_fit;
  logic ld_fit;
  int   cycles;

  `include "lsq_model.svh"

  lsq_top u_dut (.*);

  initial clock = 1'b0;
  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: the run did not finish after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  // Small address pool so that stores and loads collide often
  function automatic logic [lsq_pkg::ADDR_W-1:0] pool_addr();
    logic [31:0]                rnd;
    logic [lsq_pkg::ADDR_W-1:0] a;
    rnd    = $urandom;
    a      = 29'h100;
    a[1:0] = rnd[1:0];
    return a;
  endfunction

  task automatic drive_idle();
    st_dispatch      = '0;
    ld_dispatch      = '0;
    st_exec_valid    = '0;
    st_exec_idx      = '0;
    st_exec_addr     = '0;
    st_exec_data     = '0;
    ld_exec_valid    = '0;
    ld_exec_idx      = '0;
    ld_exec_addr     = '0;
    st_retire        = '0;
    ld_retire        = '0;
    rollback_en      = 1'b0;
    sq_rollback_tail = '0;
    lq_rollback_tail = '0;
  endtask

  task automatic drive_cycle();
    logic [31:0]               rnd;
    int                        st_occ;
    int                        ld_occ;
    logic [lsq_pkg::IDX_W-1:0] slot;
    drive_idle();
    st_occ           = occupancy(m_sq_head, m_sq_tail);
    ld_occ           = occupancy(m_lq_head, m_lq_tail);
    rnd              = $urandom;
    st_dispatch      = rnd[1:0];
    ld_dispatch      = rnd[3:2];
    rollback_en      = (rnd[7:4] == 4'd0);
    sq_rollback_tail = wrap(int'(m_sq_head) + int'($urandom_range(0, st_occ)));
    lq_rollback_tail = wrap(int'(m_lq_head) + int'($urandom_range(0, ld_occ)));
    for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
      if (st_occ > 0 && $urandom_range(0, 1) == 1) begin
        slot = wrap(int'(m_sq_head) + int'($urandom_range(0, st_occ - 1)));
        if (!m_sq_exec[slot] && !(i == 1 && st_exec_valid[0] && st_exec_idx[0] == slot)) begin
          st_exec_valid[i] = 1'b1;
          st_exec_idx[i]   = slot;
          st_exec_addr[i]  = pool_addr();
          st_exec_data[i]  = {$urandom, $urandom};
        end
      end
      if (ld_occ > 0 && $urandom_range(0, 1) == 1) begin
        slot = wrap(int'(m_lq_head) + int'($urandom_range(0, ld_occ - 1)));
        if (!m_lq_exec[slot] && !(i == 1 && ld_exec_valid[0] && ld_exec_idx[0] == slot)) begin
          ld_exec_valid[i] = 1'b1;
          ld_exec_idx[i]   = slot;
          ld_exec_addr[i]  = pool_addr();
        end
      end
    end
    // Retire only executed heads, never in a rollback cycle
    if (!rollback_en && st_occ > 0 && m_sq_exec[m_sq_head] && rnd[8]) begin
      st_retire[0] = 1'b1;
      st_retire[1] = st_occ > 1 && m_sq_exec[wrap(int'(m_sq_head) + 1)] && rnd[9];
    end
    if (!rollback_en && ld_occ > 0 && m_lq_exec[m_lq_head] && rnd[10]) begin
      ld_retire[0] = 1'b1;
      ld_retire[1] = ld_occ > 1 && m_lq_exec[wrap(int'(m_lq_head) + 1)] && rnd[11];
    end
  endtask

  task automatic check_cycle();
    logic [lsq_pkg::NUM_SUPER-1:0][lsq_pkg::IDX_W-1:0] exp_idx;
    logic                                              hit;
    logic [lsq_pkg::DATA_W-1:0]                        data;
    logic                                              v;
    logic [lsq_pkg::IDX_W-1:0]                         vidx;
    logic                                              rdy;
    logic [lsq_pkg::IDX_W-1:0]                         slot;
    int                                                below;
    below  = 0;
    st_fit = occupancy(m_sq_head, m_sq_tail) + int'(st_dispatch[0]) + int'(st_dispatch[1])
             < lsq_pkg::NUM_LSQ;
    for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
      exp_idx[i] = wrap(int'(m_sq_tail) + below);
      below      = below + int'(st_dispatch[i]);
    end
    check_alloc("store", st_dispatch_ready, st_fit, st_alloc_idx, exp_idx);
    below  = 0;
    ld_fit = occupancy(m_lq_head, m_lq_tail) + int'(ld_dispatch[0]) + int'(ld_dispatch[1])
             < lsq_pkg::NUM_LSQ;
    for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
      exp_idx[i] = wrap(int'(m_lq_tail) + below);
      below      = below + int'(ld_dispatch[i]);
    end
    check_alloc("load", ld_dispatch_ready, ld_fit, ld_alloc_idx, exp_idx);
    below = 0;
    for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
      hit  = 1'b0;
      data = '0;
      if (ld_exec_valid[i]) begin
        model_forward(ld_exec_addr[i], m_lq_bound[ld_exec_idx[i]], hit, data);
      end
      check_forward(i, fwd_hit[i], hit, fwd_data[i], data);
      slot = wrap(int'(m_sq_head) + below);
      rdy  = below < occupancy(m_sq_head, m_sq_tail) && m_sq_exec[slot] == 1'b1;
      check_cache_write(i, st_retire_ready[i], rdy, cache_wr_en[i], st_retire[i] && rdy,
                        cache_wr_addr[i], m_sq_addr[slot], cache_wr_data[i], m_sq_data[slot]);
      below = below + int'(st_retire[i]);
      v     = 1'b0;
      vidx  = '0;
      if (st_exec_valid[i]) begin
        model_violation(st_exec_idx[i], st_exec_addr[i], v, vidx);
      end
      check_violation(i, violation[i], v, violation_lq_idx[i], vidx);
    end
  endtask

  task automatic advance_model();
    logic [lsq_pkg::IDX_W-1:0] sq_t;
    logic [lsq_pkg::IDX_W-1:0] lq_t;
    sq_t = m_sq_tail;
    lq_t = m_lq_tail;
    // A request that does not fit allocates nothing
    for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
      if (!rollback_en && st_fit && st_dispatch[i]) begin
        m_sq_exec[sq_t] = 1'b0;
        sq_t            = sq_t + 1'b1;
      end
    end
    // Stores of the same group count as older than its loads
    for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
      if (!rollback_en && ld_fit && ld_dispatch[i]) begin
        m_lq_exec[lq_t]  = 1'b0;
        m_lq_bound[lq_t] = sq_t;
        lq_t             = lq_t + 1'b1;
      end
    end
    for (int i = 0; i < lsq_pkg::NUM_SUPER; i++) begin
      if (st_exec_valid[i]) begin
        m_sq_exec[st_exec_idx[i]] = 1'b1;
        m_sq_addr[st_exec_idx[i]] = st_exec_addr[i];
        m_sq_data[st_exec_idx[i]] = st_exec_data[i];
      end
      if (ld_exec_valid[i]) begin
        m_lq_exec[ld_exec_idx[i]] = 1'b1;
        m_lq_addr[ld_exec_idx[i]] = ld_exec_addr[i];
      end
      if (st_retire[i]) m_sq_head = m_sq_head + 1'b1;
      if (ld_retire[i]) m_lq_head = m_lq_head + 1'b1;
    end
    m_sq_tail = rollback_en ? sq_rollback_tail : sq_t;
    m_lq_tail = rollback_en ? lq_rollback_tail : lq_t;
  endtask

  initial begin
    void'($urandom(32'hf0ef14fa));
    cycles = 0;
    reset  = 1'b1;
    drive_idle();
    reset_model();
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    // Fresh queues accept a full two-lane group
    st_dispatch = 2'b11;
    ld_dispatch = 2'b11;
    #1;
    check_cycle();
    advance_model();
    repeat (RUN_CYCLES) begin
      @(negedge clock);
      drive_cycle();
      #1;
      check_cycle();
      advance_model();
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+tests
logic/lsq_pkg.sv
logic/store_forward_search.sv
logic/store_queue.sv
logic/load_queue.sv
logic/lsq_top.sv
tests/lsq_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the LSQ testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module lsq_tb -f flist.f -o lsq_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/lsq_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
  exit $status
fi
exit 0
